// ==== Bender.yml ====
package:
  name: armExc

sources:
  - include_dirs:
      - design
    files:
      - design/armExcPkg.sv
      - design/interruptSync.sv
      - design/clearTokenPipe.sv
      - design/exceptionPriority.sv
      - design/exceptionUnit.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/exceptionChecker.sv
      - dv/exceptionUnitTb.sv

// ==== armExc.f ====
+incdir+design
design/armExcPkg.sv
design/interruptSync.sv
design/clearTokenPipe.sv
design/exceptionPriority.sv
design/exceptionUnit.sv
dv/exceptionChecker.sv
dv/exceptionUnitTb.sv

// ==== design/armExcPkg.sv ====
package armExcPkg;

  // Cause behind a reported vector
  // causeNone when no vector is valid
  typedef enum logic [2:0] {
    causeNone          = 3'd0,
    // Synchronous, reported in E
    causeUndefined     = 3'd1,
    causeSwi           = 3'd2,
    causePrefetchAbort = 3'd3,
    // Synchronous, reported in M
    causeDataAbort     = 3'd4,
    // Asynchronous, reported when the clear token hits W
    causeIrq           = 3'd5,
    causeFiq           = 3'd6
  } excCause_e;

  // Kind of interrupt a pipeline-clear token stands for
  // One bit, travels E -> M -> W with the token
  typedef enum logic {
    kindIrq = 1'b0,
    kindFiq = 1'b1
  } tokenKind_e;

endpackage

// ==== design/armExc_settings.svh ====
`ifndef ARMEXC_SETTINGS_SVH
`define ARMEXC_SETTINGS_SVH

// Flops per interrupt synchronizer chain
`define SYNC_STAGES 2

// Base of the exception vector table
`define VECTOR_BASE 32'h0000_0000

// ARM vector table offsets, relative to VECTOR_BASE
// Undefined instruction
`define VEC_UNDEF 8'h04
// Software interrupt
`define VEC_SWI   8'h08
// Prefetch abort
`define VEC_PABT  8'h0C
// Data abort
`define VEC_DABT  8'h10
// Normal interrupt
`define VEC_IRQ   8'h18
// Fast interrupt
`define VEC_FIQ   8'h1C

`endif

// ==== design/clearTokenPipe.sv ====
`timescale 1ns/100ps

module clearTokenPipe (
  input  logic                  clk,
  input  logic                  rstN,
  // Token injected into D this cycle lands in E
  input  logic                  injectValid,
  input  armExcPkg::tokenKind_e injectKind,
  // Kills for the tokens leaving E and M
  input  logic                  exceptionFlushE,
  input  logic                  exceptionFlushM,
  // Any token in flight
  output logic                  tokenBusy,
  // Token sitting in W this cycle
  output logic                  tokenAtW,
  output armExcPkg::tokenKind_e tokenKindW
);

  import armExcPkg::*;

  // Valid bits per stage
  logic validE;
  logic validM;
  logic validW;

  // Kind per stage is only meaningful with its valid bit
  tokenKind_e kindE;
  tokenKind_e kindM;
  tokenKind_e kindW;

  // Valid bits shift forward every cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validE <= 1'b0;
      validM <= 1'b0;
      validW <= 1'b0;
    end else begin
      // New token from D
      validE <= injectValid;
      // Flush of E kills the token moving to M
      validM <= validE & ~exceptionFlushE;
      // Flush of M kills the token moving to W
      validW <= validM & ~exceptionFlushM;
      // W falls empty unless M hands over
    end
  end

  // Kind follows the valid bits
  always_ff @(posedge clk) begin
    kindE <= injectKind;
    kindM <= kindE;
    kindW <= kindM;
  end

  // Blocks further injection while anything is in flight
  assign tokenBusy = validE | validM | validW;

  // W holds a token for exactly one cycle
  assign tokenAtW   = validW;
  assign tokenKindW = kindW;

endmodule

// ==== design/exceptionPriority.sv ====
`timescale 1ns/100ps
`include "armExc_settings.svh"

module exceptionPriority (
  // Synchronized, masked interrupt requests
  input  logic                  irqReq,
  input  logic                  fiqReq,
  // Synchronous exception flags
  input  logic                  undefinedInstrE,
  input  logic                  swiE,
  input  logic                  prefetchAbortE,
  input  logic                  dataAbortM,
  // Token pipeline status
  input  logic                  tokenBusy,
  input  logic                  tokenAtW,
  input  armExcPkg::tokenKind_e tokenKindW,
  // Interrupt entry, one cycle pulse
  output logic                  irqAssert,
  output logic                  fiqAssert,
  // Pipeline controls
  output logic                  pipelineClearD,
  output logic                  exceptionFlushD,
  output logic                  exceptionFlushE,
  output logic                  exceptionFlushM,
  output logic                  exceptionStallD,
  output logic                  exceptionKillStallD,
  // Token injection into D
  output logic                  injectValid,
  output armExcPkg::tokenKind_e injectKind,
  // Handler vector
  output logic                  vectorValid,
  output armExcPkg::excCause_e  vectorCause,
  output logic [31:0]           vectorAddress
);

  import armExcPkg::*;

  // Offset of the winning cause into the table
  logic [7:0] vectorOffset;

  // Ordered decision, first match wins
  always_comb begin
    // Quiet defaults
    irqAssert           = 1'b0;
    fiqAssert           = 1'b0;
    pipelineClearD      = 1'b0;
    exceptionFlushD     = 1'b0;
    exceptionFlushE     = 1'b0;
    exceptionFlushM     = 1'b0;
    exceptionStallD     = 1'b0;
    exceptionKillStallD = 1'b0;
    injectValid         = 1'b0;
    injectKind          = kindIrq;
    vectorValid         = 1'b0;
    vectorCause         = causeNone;

    if (tokenAtW) begin
      // Token reached W, enter the handler
      // Sync exceptions this cycle are dropped
      vectorValid = 1'b1;
      if (tokenKindW == kindFiq) begin
        fiqAssert   = 1'b1;
        vectorCause = causeFiq;
      end else begin
        irqAssert   = 1'b1;
        vectorCause = causeIrq;
      end
    end else if (dataAbortM) begin
      // Data abort, flush everything up to M
      exceptionFlushD     = 1'b1;
      exceptionFlushE     = 1'b1;
      exceptionFlushM     = 1'b1;
      exceptionKillStallD = 1'b1;
      vectorValid         = 1'b1;
      vectorCause         = causeDataAbort;
    end else if (fiqReq && !tokenBusy) begin
      // FIQ, drop a clear token into D
      pipelineClearD  = 1'b1;
      exceptionFlushD = 1'b1;
      exceptionStallD = 1'b1;
      injectValid     = 1'b1;
      injectKind      = kindFiq;
    end else if (irqReq && !tokenBusy) begin
      // IRQ, same as FIQ with the other kind
      pipelineClearD  = 1'b1;
      exceptionFlushD = 1'b1;
      exceptionStallD = 1'b1;
      injectValid     = 1'b1;
      injectKind      = kindIrq;
    end else if (prefetchAbortE) begin
      // Prefetch abort wins over undef
      exceptionFlushD = 1'b1;
      exceptionFlushE = 1'b1;
      exceptionFlushM = 1'b1;
      vectorValid     = 1'b1;
      vectorCause     = causePrefetchAbort;
    end else if (undefinedInstrE) begin
      exceptionFlushD = 1'b1;
      exceptionFlushE = 1'b1;
      exceptionFlushM = 1'b1;
      vectorValid     = 1'b1;
      vectorCause     = causeUndefined;
    end else if (swiE) begin
      // SWI only squashes the instruction behind it
      exceptionFlushD = 1'b1;
      vectorValid     = 1'b1;
      vectorCause     = causeSwi;
    end
  end

  // Table lookup by cause
  always_comb begin
    case (vectorCause)
      causeUndefined:     vectorOffset = `VEC_UNDEF;
      causeSwi:           vectorOffset = `VEC_SWI;
      causePrefetchAbort: vectorOffset = `VEC_PABT;
      causeDataAbort:     vectorOffset = `VEC_DABT;
      causeIrq:           vectorOffset = `VEC_IRQ;
      causeFiq:           vectorOffset = `VEC_FIQ;
      // No cause, points at the base
      default:            vectorOffset = 8'h00;
    endcase
  end

  // Base plus zero-extended offset
  assign vectorAddress = `VECTOR_BASE + {24'h00_0000, vectorOffset};

endmodule

// ==== design/exceptionUnit.sv ====
`timescale 1ns/100ps
`include "armExc_settings.svh"

module exceptionUnit (
  input  logic                 clk,
  input  logic                 rstN,
  // Synchronous exception flags
  input  logic                 undefinedInstrE,
  input  logic                 swiE,
  input  logic                 prefetchAbortE,
  input  logic                 dataAbortM,
  // Asynchronous interrupt pins and their enables
  input  logic                 irq,
  input  logic                 fiq,
  input  logic                 irqEnabled,
  input  logic                 fiqEnabled,
  // Interrupt entry
  output logic                 irqAssert,
  output logic                 fiqAssert,
  // Pipeline controls
  output logic                 pipelineClearD,
  output logic                 exceptionFlushD,
  output logic                 exceptionFlushE,
  output logic                 exceptionFlushM,
  output logic                 exceptionStallD,
  output logic                 exceptionKillStallD,
  // Handler vector
  output logic                 vectorValid,
  output armExcPkg::excCause_e vectorCause,
  output logic [31:0]          vectorAddress
);

  import armExcPkg::*;

  // Synchronizer to priority logic
  logic       irqReq;
  logic       fiqReq;

  // Priority logic to token pipe
  logic       injectValid;
  tokenKind_e injectKind;

  // Token pipe back to priority logic
  logic       tokenBusy;
  logic       tokenAtW;
  tokenKind_e tokenKindW;

  // Pin synchronizers and masking
  interruptSync #(
    .SyncStages (`SYNC_STAGES)
  ) interruptSync_i (
    .clk        (clk),
    .rstN       (rstN),
    .irq        (irq),
    .fiq        (fiq),
    .irqEnabled (irqEnabled),
    .fiqEnabled (fiqEnabled),
    .irqReq     (irqReq),
    .fiqReq     (fiqReq)
  );

  // In-flight clear tokens, killed by E/M flushes
  clearTokenPipe clearTokenPipe_i (
    .clk             (clk),
    .rstN            (rstN),
    .injectValid     (injectValid),
    .injectKind      (injectKind),
    .exceptionFlushE (exceptionFlushE),
    .exceptionFlushM (exceptionFlushM),
    .tokenBusy       (tokenBusy),
    .tokenAtW        (tokenAtW),
    .tokenKindW      (tokenKindW)
  );

  // Combinational priority and vector
  exceptionPriority exceptionPriority_i (
    .irqReq              (irqReq),
    .fiqReq              (fiqReq),
    .undefinedInstrE     (undefinedInstrE),
    .swiE                (swiE),
    .prefetchAbortE      (prefetchAbortE),
    .dataAbortM          (dataAbortM),
    .tokenBusy           (tokenBusy),
    .tokenAtW            (tokenAtW),
    .tokenKindW          (tokenKindW),
    .irqAssert           (irqAssert),
    .fiqAssert           (fiqAssert),
    .pipelineClearD      (pipelineClearD),
    .exceptionFlushD     (exceptionFlushD),
    .exceptionFlushE     (exceptionFlushE),
    .exceptionFlushM     (exceptionFlushM),
    .exceptionStallD     (exceptionStallD),
    .exceptionKillStallD (exceptionKillStallD),
    .injectValid         (injectValid),
    .injectKind          (injectKind),
    .vectorValid         (vectorValid),
    .vectorCause         (vectorCause),
    .vectorAddress       (vectorAddress)
  );

endmodule

// ==== design/interruptSync.sv ====
`timescale 1ns/100ps
`include "armExc_settings.svh"

module interruptSync #(
  // Flops in each synchronizer chain
  parameter int SyncStages = `SYNC_STAGES
) (
  input  logic clk,
  input  logic rstN,
  // Asynchronous interrupt pins
  input  logic irq,
  input  logic fiq,
  // CPSR style enables that are already synchronous
  input  logic irqEnabled,
  input  logic fiqEnabled,
  // Synchronized and masked requests
  output logic irqReq,
  output logic fiqReq
);

  // Lane positions inside the shared chain
  localparam int IrqLane = 0;
  localparam int FiqLane = 1;

  // Both pins sampled together
  logic [1:0] pinLevels;

  // One 2-bit lane per stage with stage 0 nearest the pins
  logic [SyncStages-1:0][1:0] syncQ;

  // Last stage of the chain
  logic [1:0] syncOut;

  assign pinLevels[IrqLane] = irq;
  assign pinLevels[FiqLane] = fiq;

  // Shift chain from the pins toward the priority logic
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      syncQ <= '0;
    end else begin
      syncQ[0] <= pinLevels;
      // Each later stage takes the one before it
      for (int i = 1; i < SyncStages; i++) begin
        syncQ[i] <= syncQ[i-1];
      end
    end
  end

  assign syncOut = syncQ[SyncStages-1];

  // Mask after the chain
  // A disabled line never reaches the priority logic
  assign irqReq = syncOut[IrqLane] & irqEnabled;
  assign fiqReq = syncOut[FiqLane] & fiqEnabled;

endmodule

// ==== dv/exceptionChecker.sv ====
`timescale 1ns/100ps
`include "armExc_settings.svh"

module exceptionChecker (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [191:0]         testName,
  // DUT inputs
  input  logic                 undefinedInstrE,
  input  logic                 swiE,
  input  logic                 prefetchAbortE,
  input  logic                 dataAbortM,
  input  logic                 irq,
  input  logic                 fiq,
  input  logic                 irqEnabled,
  input  logic                 fiqEnabled,
  // DUT outputs
  input  logic                 irqAssert,
  input  logic                 fiqAssert,
  input  logic                 pipelineClearD,
  input  logic                 exceptionFlushD,
  input  logic                 exceptionFlushE,
  input  logic                 exceptionFlushM,
  input  logic                 exceptionStallD,
  input  logic                 exceptionKillStallD,
  input  logic                 vectorValid,
  input  armExcPkg::excCause_e vectorCause,
  input  logic [31:0]          vectorAddress,
  // Totals for the closing line
  output int                   checkCount,
  output int                   errorCount
);

  import armExcPkg::*;

  typedef struct packed {
    logic        irqA;
    logic        fiqA;
    logic        clearD;
    logic        flushD;
    logic        flushE;
    logic        flushM;
    logic        stallD;
    logic        killStallD;
    logic        inject;
    logic        injectFiq;
    logic        vecValid;
    logic [2:0]  cause;
    logic [31:0] addr;
  } expected_t;

  // Shadow synchronizer chains, index 0 nearest the pins
  logic [`SYNC_STAGES-1:0] irqChain;
  logic [`SYNC_STAGES-1:0] fiqChain;

  // Shadow token stages, kind 1 means fiq
  logic tokE, tokM, tokW;
  logic fiqE, fiqM, fiqW;

  expected_t exp;

  // Ordered rules, first match wins
  function automatic expected_t refModel(
    input logic irqReq, input logic fiqReq,
    input logic undef, input logic swi, input logic pabt, input logic dabt,
    input logic busy, input logic atW, input logic kindFiqW);
    expected_t e;
    e = '0;
    e.cause = causeNone;
    e.addr = `VECTOR_BASE;
    if (atW) begin
      // Handler entry, sync flags ignored
      e.vecValid = 1'b1;
      e.fiqA = kindFiqW;
      e.irqA = !kindFiqW;
      e.cause = kindFiqW ? causeFiq : causeIrq;
      e.addr = `VECTOR_BASE + (kindFiqW ? `VEC_FIQ : `VEC_IRQ);
    end else if (dabt) begin
      {e.flushD, e.flushE, e.flushM, e.killStallD, e.vecValid} = 5'b11111;
      e.cause = causeDataAbort;
      e.addr = `VECTOR_BASE + `VEC_DABT;
    end else if ((fiqReq || irqReq) && !busy) begin
      // Token injection, fiq first
      {e.clearD, e.flushD, e.stallD, e.inject} = 4'b1111;
      e.injectFiq = fiqReq;
    end else if (pabt || undef) begin
      {e.flushD, e.flushE, e.flushM, e.vecValid} = 4'b1111;
      e.cause = pabt ? causePrefetchAbort : causeUndefined;
      e.addr = `VECTOR_BASE + (pabt ? `VEC_PABT : `VEC_UNDEF);
    end else if (swi) begin
      e.flushD = 1'b1;
      e.vecValid = 1'b1;
      e.cause = causeSwi;
      e.addr = `VECTOR_BASE + `VEC_SWI;
    end
    return e;
  endfunction

  task automatic compareValue(input string field, input logic [31:0] expVal,
                              input logic [31:0] actVal);
    checkCount++;
    if (actVal !== expVal) begin
      errorCount++;
      $display("FAILED %0s %0s expected %h actual %h at %0t",
               testName, field, expVal, actVal, $time);
    end
  endtask

  initial begin
    checkCount = 0;
    errorCount = 0;
  end

  // Compare mid-cycle, then step the shadow to the next edge
  always @(negedge clk) begin
    if (!rstN) begin
      irqChain = '0;
      fiqChain = '0;
      {tokE, tokM, tokW} = 3'b000;
      {fiqE, fiqM, fiqW} = 3'b000;
    end
    exp = refModel(irqChain[`SYNC_STAGES-1] & irqEnabled,
                   fiqChain[`SYNC_STAGES-1] & fiqEnabled,
                   undefinedInstrE, swiE, prefetchAbortE, dataAbortM,
                   tokE | tokM | tokW, tokW, fiqW);
    compareValue("irqAssert", exp.irqA, irqAssert);
    compareValue("fiqAssert", exp.fiqA, fiqAssert);
    compareValue("pipelineClearD", exp.clearD, pipelineClearD);
    compareValue("exceptionFlushD", exp.flushD, exceptionFlushD);
    compareValue("exceptionFlushE", exp.flushE, exceptionFlushE);
    compareValue("exceptionFlushM", exp.flushM, exceptionFlushM);
    compareValue("exceptionStallD", exp.stallD, exceptionStallD);
    compareValue("exceptionKillStallD", exp.killStallD, exceptionKillStallD);
    compareValue("vectorValid", exp.vecValid, vectorValid);
    compareValue("vectorCause", exp.cause, vectorCause);
    compareValue("vectorAddress", exp.addr, vectorAddress);
    if (rstN) begin
      // Token moves on, flushes kill what leaves E or M
      tokW = tokM & !exp.flushM;
      fiqW = fiqM;
      tokM = tokE & !exp.flushE;
      fiqM = fiqE;
      tokE = exp.inject;
      fiqE = exp.injectFiq;
      for (int i = `SYNC_STAGES - 1; i > 0; i--) begin
        irqChain[i] = irqChain[i-1];
        fiqChain[i] = fiqChain[i-1];
      end
      irqChain[0] = irq;
      fiqChain[0] = fiq;
    end
  end

endmodule

// ==== dv/exceptionUnitTb.sv ====
`timescale 1ns/100ps

module exceptionUnitTb;

  import armExcPkg::*;

  // Directed plus random plus margin
  localparam int TimeoutCycles = 100 + 400 + 100;
  localparam int RandomCycles  = 400;

  logic clk;
  logic rstN;
  logic undefinedInstrE;
  logic swiE;
  logic prefetchAbortE;
  logic dataAbortM;
  logic irq;
  logic fiq;
  logic irqEnabled;
  logic fiqEnabled;
  logic irqAssert;
  logic fiqAssert;
  logic pipelineClearD;
  logic exceptionFlushD;
  logic exceptionFlushE;
  logic exceptionFlushM;
  logic exceptionStallD;
  logic exceptionKillStallD;
  logic vectorValid;
  excCause_e vectorCause;
  logic [31:0] vectorAddress;
  logic [191:0] testName;
  logic [31:0] rngState;
  int cycleCount;
  int checkCount;
  int errorCount;

  exceptionUnit dut_i (.*);

  exceptionChecker checker_i (.*);

  always #50 clk = ~clk;

  // Hang guard
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // One cycle of synchronous flags
  task automatic driveSync(input logic dabt, input logic pabt, input logic undef,
                           input logic swi);
    @(posedge clk);
    dataAbortM      <= dabt;
    prefetchAbortE  <= pabt;
    undefinedInstrE <= undef;
    swiE            <= swi;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) driveSync(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // Injection seen mid-cycle
  task automatic waitClearD();
    do @(negedge clk); while (!pipelineClearD);
  endtask

  task automatic waitIrqEntry();
    do @(negedge clk); while (!irqAssert);
  endtask

  task automatic waitFiqEntry();
    do @(negedge clk); while (!fiqAssert);
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    {undefinedInstrE, swiE, prefetchAbortE, dataAbortM} = 4'b0000;
    {irq, fiq, irqEnabled, fiqEnabled} = 4'b0000;
    rngState = 32'd48;
    cycleCount = 0;
    testName = "resetQuiet";
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    idleCycles(3);

    // Every mix of the four flags
    testName = "syncPriority";
    for (int i = 1; i < 16; i++) begin
      driveSync(i[3], i[2], i[1], i[0]);
    end
    idleCycles(1);

    testName = "irqDelivery";
    @(posedge clk);
    irqEnabled <= 1'b1;
    irq <= 1'b1;
    waitClearD();
    waitIrqEntry();
    @(posedge clk);
    irq <= 1'b0;
    idleCycles(8);

    // Both lines at once and fiq goes first
    testName = "fiqWins";
    @(posedge clk);
    fiqEnabled <= 1'b1;
    fiq <= 1'b1;
    irq <= 1'b1;
    waitFiqEntry();
    @(posedge clk);
    fiq <= 1'b0;
    irq <= 1'b0;
    idleCycles(8);

    testName = "maskSingleToken";
    @(posedge clk);
    irqEnabled <= 1'b0;
    irq <= 1'b1;
    idleCycles(6);
    @(posedge clk);
    irqEnabled <= 1'b1;
    waitClearD();
    idleCycles(2);
    @(posedge clk);
    irq <= 1'b0;
    idleCycles(8);

    // Abort kills the token in E
    testName = "killPreempt";
    @(posedge clk);
    irq <= 1'b1;
    waitClearD();
    driveSync(1'b1, 1'b0, 1'b0, 1'b0);
    driveSync(1'b0, 1'b0, 1'b0, 1'b0);
    waitClearD();
    // Abort kills the re-injected token in M
    idleCycles(1);
    driveSync(1'b1, 1'b0, 1'b0, 1'b0);
    driveSync(1'b0, 1'b0, 1'b0, 1'b0);
    waitClearD();
    // Token in W beats all sync flags
    idleCycles(2);
    driveSync(1'b1, 1'b1, 1'b1, 1'b1);
    driveSync(1'b0, 1'b0, 1'b0, 1'b0);
    irq <= 1'b0;
    idleCycles(8);

    // Sparse flags with slow interrupt and enable toggles
    testName = "randomRegression";
    for (int i = 0; i < RandomCycles; i++) begin
      rngState = xorshift(rngState);
      @(posedge clk);
      undefinedInstrE <= (rngState[3:0] == 4'h0);
      swiE            <= (rngState[7:4] == 4'h0);
      prefetchAbortE  <= (rngState[11:8] == 4'h0);
      dataAbortM      <= (rngState[15:12] == 4'h0);
      if (rngState[20:16] == 5'd0) irq <= !irq;
      if (rngState[25:21] == 5'd0) fiq <= !fiq;
      if (rngState[29:26] == 4'd0) irqEnabled <= !irqEnabled;
      if (rngState[31:28] == 4'd1) fiqEnabled <= !fiqEnabled;
    end
    idleCycles(4);

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
